/* filelist.f */
+incdir+test
logic/mips_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/branch_resolve.sv
logic/id_ex_reg.sv
logic/id_stage.sv
test/tb_id_stage.sv

/* logic/branch_resolve.sv */
module branch_resolve (
	input  mips_pkg::alu_op_t aluop_i,
	input  mips_pkg::word_t   pc_i,
	input  mips_pkg::inst_u   inst_i,
	input  mips_pkg::word_t   reg1_i,
	input  mips_pkg::word_t   reg2_i,
	output logic              branch_flag_o,
	output mips_pkg::word_t   branch_target_o,
	output mips_pkg::word_t   link_addr_o
);

	mips_pkg::word_t pc_plus_4;
	mips_pkg::word_t pc_plus_8;
	mips_pkg::word_t branch_addr;
	mips_pkg::word_t jump_addr;
	logic            reg1_neg;
	logic            reg1_zero;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;

	// pc relative, offset counted in words
	assign branch_addr = pc_plus_4 +
		{{14{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16, 2'b00};
	// stays inside the current 256 MB region
	assign jump_addr = {pc_plus_4[31:28], inst_i.j_fmt.target26, 2'b00};

	assign reg1_neg  = reg1_i[31];
	assign reg1_zero = reg1_i == '0;

	always_comb begin
		branch_flag_o   = 1'b0;
		branch_target_o = branch_addr;
		link_addr_o     = '0;
		case (aluop_i)
			mips_pkg::ALU_J: begin
				branch_flag_o   = 1'b1;
				branch_target_o = jump_addr;
			end
			mips_pkg::ALU_JAL: begin
				branch_flag_o   = 1'b1;
				branch_target_o = jump_addr;
				link_addr_o     = pc_plus_8;
			end
			mips_pkg::ALU_JR: begin
				branch_flag_o   = 1'b1;
				branch_target_o = reg1_i;
			end
			mips_pkg::ALU_JALR: begin
				branch_flag_o   = 1'b1;
				branch_target_o = reg1_i;
				link_addr_o     = pc_plus_8;
			end
			mips_pkg::ALU_BEQ:  branch_flag_o = reg1_i == reg2_i;
			mips_pkg::ALU_BNE:  branch_flag_o = reg1_i != reg2_i;
			mips_pkg::ALU_BGTZ: branch_flag_o = !reg1_neg && !reg1_zero;
			mips_pkg::ALU_BLEZ: branch_flag_o = reg1_neg || reg1_zero;
			mips_pkg::ALU_BGEZ, mips_pkg::ALU_BGEZAL: begin
				// rt bit 0 picks >= 0 over < 0, bit 4 asks for a link
				branch_flag_o = inst_i.i_fmt.rt[0] ? !reg1_neg : reg1_neg;
				if (inst_i.i_fmt.rt[4]) begin
					link_addr_o = pc_plus_8;
				end
			end
			default: branch_flag_o = 1'b0;
		endcase
		if (!branch_flag_o) begin
			branch_target_o = '0;
		end
	end

	// taken branches and jumps land on a word
	always_comb begin
		a_target_aligned: assert final (!branch_flag_o || branch_target_o[1:0] == 2'b00)
			else $error("taken branch with unaligned target %h", branch_target_o);
	end

endmodule

/* logic/id_ex_reg.sv */
module id_ex_reg (
	input  logic                clk,
	input  logic                arst_n_i,
	input  mips_pkg::alu_op_t   aluop_i,
	input  mips_pkg::alu_sel_t  alusel_i,
	input  mips_pkg::word_t     reg1_i,
	input  mips_pkg::word_t     reg2_i,
	input  mips_pkg::reg_addr_t wd_i,
	input  logic                wreg_i,
	input  mips_pkg::word_t     link_addr_i,
	input  logic                in_delayslot_i,
	output mips_pkg::alu_op_t   ex_aluop_o,
	output mips_pkg::alu_sel_t  ex_alusel_o,
	output mips_pkg::word_t     ex_reg1_o,
	output mips_pkg::word_t     ex_reg2_o,
	output mips_pkg::reg_addr_t ex_wd_o,
	output logic                ex_wreg_o,
	output mips_pkg::word_t     ex_link_addr_o,
	output logic                ex_in_delayslot_o
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_aluop_o        <= mips_pkg::ALU_NOP;
			ex_alusel_o       <= mips_pkg::SEL_NOP;
			ex_wd_o           <= '0;
			ex_wreg_o         <= 1'b0;
			ex_in_delayslot_o <= 1'b0;
		end else begin
			ex_aluop_o        <= aluop_i;
			ex_alusel_o       <= alusel_i;
			ex_wd_o           <= wd_i;
			ex_wreg_o         <= wreg_i;
			ex_in_delayslot_o <= in_delayslot_i;
		end
	end

	always_ff @(posedge clk) begin
		ex_reg1_o      <= reg1_i;
		ex_reg2_o      <= reg2_i;
		ex_link_addr_o <= link_addr_i;
	end

	// execute must see a bubble on the first edge out of reset
	a_no_write_after_reset: assert property (@(posedge clk) $rose(arst_n_i) |-> !ex_wreg_o)
		else $error("register write pending right after reset");

endmodule

/* logic/id_stage.sv */
module id_stage (
	input  logic                clk,
	input  logic                arst_n_i,
	input  mips_pkg::word_t     pc_i,
	input  mips_pkg::inst_u     inst_i,
	input  logic                is_in_delayslot_i,
	input  logic                ex_wreg_i,
	input  mips_pkg::reg_addr_t ex_wd_i,
	input  mips_pkg::word_t     ex_wdata_i,
	input  logic                mem_wreg_i,
	input  mips_pkg::reg_addr_t mem_wd_i,
	input  mips_pkg::word_t     mem_wdata_i,
	input  mips_pkg::word_t     reg1_data_i,
	input  mips_pkg::word_t     reg2_data_i,
	output logic                reg1_read_o,
	output logic                reg2_read_o,
	output mips_pkg::reg_addr_t reg1_addr_o,
	output mips_pkg::reg_addr_t reg2_addr_o,
	output logic                branch_flag_o,
	output mips_pkg::word_t     branch_target_o,
	output mips_pkg::word_t     link_addr_o,
	output mips_pkg::alu_op_t   ex_aluop_o,
	output mips_pkg::alu_sel_t  ex_alusel_o,
	output mips_pkg::word_t     ex_reg1_o,
	output mips_pkg::word_t     ex_reg2_o,
	output mips_pkg::reg_addr_t ex_wd_o,
	output logic                ex_wreg_o,
	output mips_pkg::word_t     ex_link_addr_o,
	output logic                ex_in_delayslot_o
);

	mips_pkg::alu_op_t   aluop;
	mips_pkg::alu_sel_t  alusel;
	mips_pkg::reg_addr_t wd;
	logic                wreg;
	mips_pkg::word_t     imm;
	mips_pkg::word_t     reg1;
	mips_pkg::word_t     reg2;

	inst_decoder u_decoder (
		.inst_i      (inst_i),
		.aluop_o     (aluop),
		.alusel_o    (alusel),
		.reg1_read_o (reg1_read_o),
		.reg2_read_o (reg2_read_o),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o),
		.wd_o        (wd),
		.wreg_o      (wreg),
		.imm_o       (imm)
	);

	operand_forward u_forward (
		.reg1_read_i (reg1_read_o),
		.reg2_read_i (reg2_read_o),
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.imm_i       (imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.reg1_o      (reg1),
		.reg2_o      (reg2)
	);

	branch_resolve u_branch (
		.aluop_i         (aluop),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.reg1_i          (reg1),
		.reg2_i          (reg2),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr_o)
	);

	id_ex_reg u_id_ex (
		.clk               (clk),
		.arst_n_i          (arst_n_i),
		.aluop_i           (aluop),
		.alusel_i          (alusel),
		.reg1_i            (reg1),
		.reg2_i            (reg2),
		.wd_i              (wd),
		.wreg_i            (wreg),
		.link_addr_i       (link_addr_o),
		.in_delayslot_i    (is_in_delayslot_i),
		.ex_aluop_o        (ex_aluop_o),
		.ex_alusel_o       (ex_alusel_o),
		.ex_reg1_o         (ex_reg1_o),
		.ex_reg2_o         (ex_reg2_o),
		.ex_wd_o           (ex_wd_o),
		.ex_wreg_o         (ex_wreg_o),
		.ex_link_addr_o    (ex_link_addr_o),
		.ex_in_delayslot_o (ex_in_delayslot_o)
	);

endmodule

/* logic/inst_decoder.sv */
module inst_decoder (
	input  mips_pkg::inst_u     inst_i,
	output mips_pkg::alu_op_t   aluop_o,
	output mips_pkg::alu_sel_t  alusel_o,
	output logic                reg1_read_o,
	output logic                reg2_read_o,
	output mips_pkg::reg_addr_t reg1_addr_o,
	output mips_pkg::reg_addr_t reg2_addr_o,
	output mips_pkg::reg_addr_t wd_o,
	output logic                wreg_o,
	output mips_pkg::word_t     imm_o
);

	mips_pkg::word_t imm_zext;
	mips_pkg::word_t imm_sext;
	logic            fixed_shift;
	logic            logic_imm;
	logic            known;

	function automatic mips_pkg::alu_op_t special_op(input logic [5:0] funct);
		case (funct)
			mips_pkg::FN_OR:   return mips_pkg::ALU_OR;
			mips_pkg::FN_AND:  return mips_pkg::ALU_AND;
			mips_pkg::FN_XOR:  return mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  return mips_pkg::ALU_NOR;
			mips_pkg::FN_SLL:  return mips_pkg::ALU_SLL;
			mips_pkg::FN_SLLV: return mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL:  return mips_pkg::ALU_SRL;
			mips_pkg::FN_SRLV: return mips_pkg::ALU_SRL;
			mips_pkg::FN_SRA:  return mips_pkg::ALU_SRA;
			mips_pkg::FN_SRAV: return mips_pkg::ALU_SRA;
			mips_pkg::FN_ADD:  return mips_pkg::ALU_ADD;
			mips_pkg::FN_ADDU: return mips_pkg::ALU_ADDU;
			mips_pkg::FN_SUB:  return mips_pkg::ALU_SUB;
			mips_pkg::FN_SUBU: return mips_pkg::ALU_SUBU;
			mips_pkg::FN_SLT:  return mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: return mips_pkg::ALU_SLTU;
			mips_pkg::FN_JR:   return mips_pkg::ALU_JR;
			mips_pkg::FN_JALR: return mips_pkg::ALU_JALR;
			default:           return mips_pkg::ALU_NOP;
		endcase
	endfunction

	function automatic mips_pkg::alu_sel_t special_sel(input logic [5:0] funct);
		case (funct)
			mips_pkg::FN_OR, mips_pkg::FN_AND, mips_pkg::FN_XOR, mips_pkg::FN_NOR:
				return mips_pkg::SEL_LOGIC;
			mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA,
			mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV:
				return mips_pkg::SEL_SHIFT;
			mips_pkg::FN_JR, mips_pkg::FN_JALR:
				return mips_pkg::SEL_JUMP_BRANCH;
			default:
				return mips_pkg::SEL_ARITHMETIC;
		endcase
	endfunction

	assign imm_zext = {16'h0000, inst_i.i_fmt.imm16};
	assign imm_sext = {{16{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16};

	assign reg1_addr_o = inst_i.r_fmt.rs;
	assign reg2_addr_o = inst_i.r_fmt.rt;

	// sll, srl and sra shift rt by shamt, rs stays zero
	assign fixed_shift = inst_i.r_fmt.funct inside
		{mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};
	// opcodes 0011xx are the logic immediates, lui among them
	assign logic_imm = inst_i.i_fmt.op[5:2] == 4'b0011;

	always_comb begin
		aluop_o     = mips_pkg::ALU_NOP;
		alusel_o    = mips_pkg::SEL_NOP;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		wd_o        = inst_i.r_fmt.rd;
		wreg_o      = 1'b0;
		imm_o       = '0;
		known       = 1'b1;
		case (inst_i.r_fmt.op)
			mips_pkg::OP_SPECIAL: begin
				aluop_o  = special_op(inst_i.r_fmt.funct);
				alusel_o = special_sel(inst_i.r_fmt.funct);
				wreg_o   = inst_i.r_fmt.funct != mips_pkg::FN_JR;
				if (fixed_shift) begin
					reg2_read_o = 1'b1;
					imm_o       = {27'd0, inst_i.r_fmt.shamt};
					known       = inst_i.r_fmt.rs == 5'd0;
				end else begin
					reg1_read_o = 1'b1;
					// jr and jalr only need rs
					reg2_read_o = alusel_o != mips_pkg::SEL_JUMP_BRANCH;
					known       = inst_i.r_fmt.shamt == 5'd0 && aluop_o != mips_pkg::ALU_NOP;
				end
			end
			mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				reg1_read_o = 1'b1;
				wd_o        = inst_i.i_fmt.rt;
				wreg_o      = 1'b1;
				alusel_o    = logic_imm ? mips_pkg::SEL_LOGIC : mips_pkg::SEL_ARITHMETIC;
				case (inst_i.i_fmt.op)
					mips_pkg::OP_ANDI:  aluop_o = mips_pkg::ALU_AND;
					mips_pkg::OP_XORI:  aluop_o = mips_pkg::ALU_XOR;
					mips_pkg::OP_ADDI:  aluop_o = mips_pkg::ALU_ADDI;
					mips_pkg::OP_ADDIU: aluop_o = mips_pkg::ALU_ADDIU;
					mips_pkg::OP_SLTI:  aluop_o = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: aluop_o = mips_pkg::ALU_SLTU;
					// ori, and lui as an or with r0
					default:            aluop_o = mips_pkg::ALU_OR;
				endcase
				if (inst_i.i_fmt.op == mips_pkg::OP_LUI) begin
					imm_o = {inst_i.i_fmt.imm16, 16'h0000};
				end else begin
					imm_o = logic_imm ? imm_zext : imm_sext;
				end
			end
			mips_pkg::OP_J: begin
				aluop_o  = mips_pkg::ALU_J;
				alusel_o = mips_pkg::SEL_JUMP_BRANCH;
			end
			mips_pkg::OP_JAL: begin
				aluop_o  = mips_pkg::ALU_JAL;
				alusel_o = mips_pkg::SEL_JUMP_BRANCH;
				wd_o     = mips_pkg::LINK_REG;
				wreg_o   = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				aluop_o = (inst_i.i_fmt.op == mips_pkg::OP_BEQ) ?
					mips_pkg::ALU_BEQ : mips_pkg::ALU_BNE;
				alusel_o    = mips_pkg::SEL_JUMP_BRANCH;
				reg1_read_o = 1'b1;
				reg2_read_o = 1'b1;
			end
			mips_pkg::OP_BGTZ, mips_pkg::OP_BLEZ: begin
				aluop_o = (inst_i.i_fmt.op == mips_pkg::OP_BGTZ) ?
					mips_pkg::ALU_BGTZ : mips_pkg::ALU_BLEZ;
				alusel_o    = mips_pkg::SEL_JUMP_BRANCH;
				reg1_read_o = 1'b1;
				known       = inst_i.i_fmt.rt == 5'd0;
			end
			mips_pkg::OP_REGIMM: begin
				alusel_o    = mips_pkg::SEL_JUMP_BRANCH;
				reg1_read_o = 1'b1;
				wd_o        = mips_pkg::LINK_REG;
				// link forms write r31 taken or not
				wreg_o      = inst_i.i_fmt.rt[4];
				case (inst_i.i_fmt.rt)
					mips_pkg::RI_BGEZ: aluop_o = mips_pkg::ALU_BGEZ;
					mips_pkg::RI_BLTZ, mips_pkg::RI_BGEZAL, mips_pkg::RI_BLTZAL:
						aluop_o = mips_pkg::ALU_BGEZAL;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		// anything unrecognised leaves as a bubble
		if (!known) begin
			aluop_o     = mips_pkg::ALU_NOP;
			alusel_o    = mips_pkg::SEL_NOP;
			reg1_read_o = 1'b0;
			reg2_read_o = 1'b0;
			wreg_o      = 1'b0;
			imm_o       = '0;
		end
	end

	always_comb begin
		a_nop_no_write: assert final (aluop_o != mips_pkg::ALU_NOP || !wreg_o)
			else $error("decoder raised a register write on a NOP");
	end

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  alu_op_t;
	typedef logic [2:0]  alu_sel_t;

	// JAL and the linking branches write here
	localparam reg_addr_t LINK_REG = 5'd31;

	// operation codes passed to execute
	localparam alu_op_t ALU_NOP    = 8'b0000_0000;
	localparam alu_op_t ALU_AND    = 8'b0010_0100;
	localparam alu_op_t ALU_OR     = 8'b0010_0101;
	localparam alu_op_t ALU_XOR    = 8'b0010_0110;
	localparam alu_op_t ALU_NOR    = 8'b0010_0111;
	localparam alu_op_t ALU_SLL    = 8'b0111_1100;
	localparam alu_op_t ALU_SRL    = 8'b0000_0010;
	localparam alu_op_t ALU_SRA    = 8'b0000_0011;
	localparam alu_op_t ALU_ADD    = 8'b0010_0000;
	localparam alu_op_t ALU_ADDU   = 8'b0010_0001;
	localparam alu_op_t ALU_SUB    = 8'b0010_0010;
	localparam alu_op_t ALU_SUBU   = 8'b0010_0011;
	localparam alu_op_t ALU_SLT    = 8'b0010_1010;
	localparam alu_op_t ALU_SLTU   = 8'b0010_1011;
	localparam alu_op_t ALU_ADDI   = 8'b0101_0101;
	localparam alu_op_t ALU_ADDIU  = 8'b0101_0110;
	localparam alu_op_t ALU_J      = 8'b0100_1111;
	localparam alu_op_t ALU_JAL    = 8'b0101_0000;
	localparam alu_op_t ALU_JR     = 8'b0000_1000;
	localparam alu_op_t ALU_JALR   = 8'b0000_1001;
	localparam alu_op_t ALU_BEQ    = 8'b0101_0001;
	localparam alu_op_t ALU_BNE    = 8'b0101_0010;
	localparam alu_op_t ALU_BLEZ   = 8'b0101_0011;
	localparam alu_op_t ALU_BGTZ   = 8'b0101_0100;
	localparam alu_op_t ALU_BGEZ   = 8'b0100_0001;
	// also carries bltz and bltzal
	localparam alu_op_t ALU_BGEZAL = 8'b0100_1011;

	// result classes
	localparam alu_sel_t SEL_NOP         = 3'b000;
	localparam alu_sel_t SEL_LOGIC       = 3'b001;
	localparam alu_sel_t SEL_SHIFT       = 3'b010;
	localparam alu_sel_t SEL_ARITHMETIC  = 3'b100;
	localparam alu_sel_t SEL_JUMP_BRANCH = 3'b110;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	// function field under SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	// rt field under REGIMM, bit 4 marks the link forms
	localparam logic [4:0] RI_BLTZ   = 5'b00000;
	localparam logic [4:0] RI_BGEZ   = 5'b00001;
	localparam logic [4:0] RI_BLTZAL = 5'b10000;
	localparam logic [4:0] RI_BGEZAL = 5'b10001;

	typedef struct packed {
		logic [5:0] op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target26;
	} j_fmt_t;

	// one instruction word, three ways to read it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} inst_u;

endpackage

/* logic/operand_forward.sv */
module operand_forward (
	input  logic                reg1_read_i,
	input  logic                reg2_read_i,
	input  mips_pkg::reg_addr_t reg1_addr_i,
	input  mips_pkg::reg_addr_t reg2_addr_i,
	input  mips_pkg::word_t     imm_i,
	input  logic                ex_wreg_i,
	input  mips_pkg::reg_addr_t ex_wd_i,
	input  mips_pkg::word_t     ex_wdata_i,
	input  logic                mem_wreg_i,
	input  mips_pkg::reg_addr_t mem_wd_i,
	input  mips_pkg::word_t     mem_wdata_i,
	input  mips_pkg::word_t     reg1_data_i,
	input  mips_pkg::word_t     reg2_data_i,
	output mips_pkg::word_t     reg1_o,
	output mips_pkg::word_t     reg2_o
);

	// newest result wins, the register file is the fallback
	function automatic mips_pkg::word_t pick_operand(
		input logic                read,
		input mips_pkg::reg_addr_t addr,
		input mips_pkg::word_t     rf_data
	);
		if (!read) begin
			return imm_i;
		end else if (ex_wreg_i && ex_wd_i == addr) begin
			return ex_wdata_i;
		end else if (mem_wreg_i && mem_wd_i == addr) begin
			return mem_wdata_i;
		end else begin
			return rf_data;
		end
	endfunction

	always_comb begin
		reg1_o = pick_operand(reg1_read_i, reg1_addr_i, reg1_data_i);
		reg2_o = pick_operand(reg2_read_i, reg2_addr_i, reg2_data_i);
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_id_stage

# a fatal check exits non-zero, the log is scanned below
./obj_dir/Vtb_id_stage > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

/* test/tb_id_tasks.svh */
`ifndef TB_ID_TASKS_SVH
`define TB_ID_TASKS_SVH

// opcode 111111 is unused, decodes as a bubble
localparam mips_pkg::word_t IDLE_INST = 32'hFFFF_FFFF;

function automatic mips_pkg::inst_u make_r(input mips_pkg::reg_addr_t rs,
	input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rd,
	input logic [4:0] shamt, input logic [5:0] funct);
	mips_pkg::inst_u w;
	w.r_fmt = '{mips_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
	return w;
endfunction

function automatic mips_pkg::inst_u make_i(input logic [5:0] op,
	input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
	mips_pkg::inst_u w;
	w.i_fmt = '{op, rs, rt, imm};
	return w;
endfunction

function automatic mips_pkg::inst_u make_j(input logic [5:0] op, input logic [25:0] target);
	mips_pkg::inst_u w;
	w.j_fmt = '{op, target};
	return w;
endfunction

// pc + 4 plus the word offset
function automatic mips_pkg::word_t rel_target(input mips_pkg::word_t pc,
	input logic [15:0] off);
	return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
endfunction

task automatic check_op(input string what, input mips_pkg::alu_op_t op_got,
	input mips_pkg::alu_op_t op_exp, input mips_pkg::alu_sel_t sel_got,
	input mips_pkg::alu_sel_t sel_exp);
	checks_done++;
	if (op_got !== op_exp || sel_got !== sel_exp) begin
		abort_run($sformatf("ERR %0t: %s op/sel expected %h/%h got %h/%h",
			$time, what, op_exp, sel_exp, op_got, sel_got));
	end
endtask

task automatic check_word(input string what, input mips_pkg::word_t got,
	input mips_pkg::word_t exp);
	checks_done++;
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s expected %h got %h", $time, what, exp, got));
	end
endtask

task automatic check_reg(input string what, input mips_pkg::reg_addr_t got,
	input mips_pkg::reg_addr_t exp);
	checks_done++;
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s expected r%0d got r%0d", $time, what, exp, got));
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	checks_done++;
	if (got !== exp) begin
		abort_run($sformatf("ERR %0t: %s expected %b got %b", $time, what, exp, got));
	end
endtask

// forwarding sources idle unless a test sets them afterwards
task automatic issue(input mips_pkg::inst_u inst, input mips_pkg::word_t pc,
	input mips_pkg::word_t rs_data, input mips_pkg::word_t rt_data);
	@(negedge clk);
	inst_i            = inst;
	pc_i              = pc;
	reg1_data_i       = rs_data;
	reg2_data_i       = rt_data;
	ex_wreg_i         = 1'b0;
	mem_wreg_i        = 1'b0;
	is_in_delayslot_i = 1'b0;
endtask

task automatic after_reset();
	check_op("reset", ex_aluop_o, mips_pkg::ALU_NOP, ex_alusel_o, mips_pkg::SEL_NOP);
	check_bit("reset wreg", ex_wreg_o, 1'b0);
	check_bit("reset delay slot", ex_in_delayslot_o, 1'b0);
	issue(IDLE_INST, '0, '0, '0);
	@(negedge clk);
	check_op("bubble", ex_aluop_o, mips_pkg::ALU_NOP, ex_alusel_o, mips_pkg::SEL_NOP);
	check_bit("bubble wreg", ex_wreg_o, 1'b0);
endtask

// ext 0 zero-extends, 1 sign-extends, 2 places in the upper half
task automatic imm_case(input string what, input logic [5:0] op,
	input mips_pkg::alu_op_t op_exp, input mips_pkg::alu_sel_t sel_exp, input int ext);
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	logic [15:0]         imm;
	mips_pkg::word_t     rs_data;
	mips_pkg::word_t     imm_exp;
	rs      = 5'($random(seed));
	rt      = 5'($random(seed));
	imm     = 16'($random(seed));
	rs_data = 32'($random(seed));
	case (ext)
		0:       imm_exp = {16'h0000, imm};
		1:       imm_exp = {{16{imm[15]}}, imm};
		default: imm_exp = {imm, 16'h0000};
	endcase
	issue(make_i(op, rs, rt, imm), '0, rs_data, '0);
	@(posedge clk);
	check_bit({what, " rs read"}, reg1_read_o, 1'b1);
	check_bit({what, " rt read"}, reg2_read_o, 1'b0);
	check_reg({what, " rs addr"}, reg1_addr_o, rs);
	@(negedge clk);
	check_op(what, ex_aluop_o, op_exp, ex_alusel_o, sel_exp);
	check_reg({what, " dest"}, ex_wd_o, rt);
	check_bit({what, " wreg"}, ex_wreg_o, 1'b1);
	check_word({what, " imm"}, ex_reg2_o, imm_exp);
	check_word({what, " rs data"}, ex_reg1_o, rs_data);
endtask

task automatic imm_forms();
	imm_case("ori", mips_pkg::OP_ORI, mips_pkg::ALU_OR, mips_pkg::SEL_LOGIC, 0);
	imm_case("andi", mips_pkg::OP_ANDI, mips_pkg::ALU_AND, mips_pkg::SEL_LOGIC, 0);
	imm_case("lui", mips_pkg::OP_LUI, mips_pkg::ALU_OR, mips_pkg::SEL_LOGIC, 2);
	imm_case("addi", mips_pkg::OP_ADDI, mips_pkg::ALU_ADDI, mips_pkg::SEL_ARITHMETIC, 1);
	imm_case("slti", mips_pkg::OP_SLTI, mips_pkg::ALU_SLT, mips_pkg::SEL_ARITHMETIC, 1);
endtask

// fixed shifts take shamt as operand 1 and leave rs at zero
task automatic reg_case(input string what, input logic [5:0] funct,
	input mips_pkg::alu_op_t op_exp, input mips_pkg::alu_sel_t sel_exp, input logic fixed);
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [4:0]          shamt;
	mips_pkg::word_t     a;
	mips_pkg::word_t     b;
	rs    = fixed ? 5'd0 : 5'($random(seed));
	shamt = fixed ? 5'($random(seed)) : 5'd0;
	rt    = 5'($random(seed));
	rd    = 5'($random(seed));
	a     = 32'($random(seed));
	b     = 32'($random(seed));
	issue(make_r(rs, rt, rd, shamt, funct), '0, a, b);
	@(posedge clk);
	check_bit({what, " rs read"}, reg1_read_o, !fixed);
	check_bit({what, " rt read"}, reg2_read_o, 1'b1);
	check_reg({what, " rs addr"}, reg1_addr_o, rs);
	check_reg({what, " rt addr"}, reg2_addr_o, rt);
	@(negedge clk);
	check_op(what, ex_aluop_o, op_exp, ex_alusel_o, sel_exp);
	check_reg({what, " dest"}, ex_wd_o, rd);
	check_bit({what, " wreg"}, ex_wreg_o, 1'b1);
	check_word({what, " operand 1"}, ex_reg1_o, fixed ? {27'd0, shamt} : a);
	check_word({what, " operand 2"}, ex_reg2_o, b);
endtask

task automatic reg_forms();
	reg_case("or", mips_pkg::FN_OR, mips_pkg::ALU_OR, mips_pkg::SEL_LOGIC, 1'b0);
	reg_case("sub", mips_pkg::FN_SUB, mips_pkg::ALU_SUB, mips_pkg::SEL_ARITHMETIC, 1'b0);
	reg_case("sllv", mips_pkg::FN_SLLV, mips_pkg::ALU_SLL, mips_pkg::SEL_SHIFT, 1'b0);
	reg_case("sll", mips_pkg::FN_SLL, mips_pkg::ALU_SLL, mips_pkg::SEL_SHIFT, 1'b1);
endtask

// src 0 expects execute data, 1 memory data, 2 register file
task automatic fwd_case(input string what, input logic ex_we, input logic ex_hit,
	input logic mem_we, input logic mem_hit, input int src);
	mips_pkg::reg_addr_t rs;
	mips_pkg::word_t     ex_data;
	mips_pkg::word_t     mem_data;
	mips_pkg::word_t     rf_data;
	mips_pkg::word_t     exp;
	rs       = 5'($random(seed));
	ex_data  = 32'($random(seed));
	mem_data = 32'($random(seed));
	rf_data  = 32'($random(seed));
	case (src)
		0:       exp = ex_data;
		1:       exp = mem_data;
		default: exp = rf_data;
	endcase
	issue(make_i(mips_pkg::OP_ORI, rs, 5'd1, 16'h0000), '0, rf_data, '0);
	ex_wreg_i   = ex_we;
	ex_wd_i     = ex_hit ? rs : ~rs;
	ex_wdata_i  = ex_data;
	mem_wreg_i  = mem_we;
	mem_wd_i    = mem_hit ? rs : ~rs;
	mem_wdata_i = mem_data;
	@(negedge clk);
	check_word(what, ex_reg1_o, exp);
endtask

task automatic forwarding();
	fwd_case("fwd ex and mem match", 1'b1, 1'b1, 1'b1, 1'b1, 0);
	fwd_case("fwd only mem matches", 1'b1, 1'b0, 1'b1, 1'b1, 1);
	fwd_case("fwd no match", 1'b1, 1'b0, 1'b1, 1'b0, 2);
	fwd_case("fwd writes disabled", 1'b0, 1'b1, 1'b0, 1'b1, 2);
endtask

task automatic flow_case(input string what, input mips_pkg::inst_u inst,
	input mips_pkg::word_t pc, input mips_pkg::word_t a, input mips_pkg::word_t b,
	input logic flag_exp, input mips_pkg::word_t target_exp, input mips_pkg::word_t link_exp,
	input mips_pkg::reg_addr_t wd_exp, input logic wreg_exp, input logic dslot);
	issue(inst, pc, a, b);
	is_in_delayslot_i = dslot;
	@(posedge clk);
	check_bit({what, " flag"}, branch_flag_o, flag_exp);
	check_word({what, " target"}, branch_target_o, target_exp);
	check_word({what, " link"}, link_addr_o, link_exp);
	@(negedge clk);
	check_bit({what, " wreg"}, ex_wreg_o, wreg_exp);
	if (wreg_exp) begin
		check_reg({what, " dest"}, ex_wd_o, wd_exp);
	end
	check_word({what, " ex link"}, ex_link_addr_o, link_exp);
	check_bit({what, " delay slot"}, ex_in_delayslot_o, dslot);
endtask

task automatic branch_case(input string what, input mips_pkg::inst_u inst,
	input mips_pkg::word_t a, input mips_pkg::word_t b, input logic taken);
	mips_pkg::word_t pc;
	pc = 32'($random(seed)) & 32'hFFFF_FFFC;
	flow_case(what, inst, pc, a, b, taken,
		taken ? rel_target(pc, inst.i_fmt.imm16) : 32'd0, '0, '0, 1'b0, 1'b0);
endtask

task automatic branches();
	logic [15:0]     off;
	mips_pkg::word_t pos;
	mips_pkg::word_t neg;
	off = 16'($random(seed));
	pos = (32'($random(seed)) & 32'h7FFF_FFFF) | 32'd1;
	neg = pos | 32'h8000_0000;
	branch_case("beq taken", make_i(mips_pkg::OP_BEQ, 5'd3, 5'd4, off), pos, pos, 1'b1);
	branch_case("beq not taken", make_i(mips_pkg::OP_BEQ, 5'd3, 5'd4, off), pos, neg, 1'b0);
	branch_case("bne taken", make_i(mips_pkg::OP_BNE, 5'd3, 5'd4, off), pos, neg, 1'b1);
	branch_case("bne not taken", make_i(mips_pkg::OP_BNE, 5'd3, 5'd4, ~off), pos, pos, 1'b0);
	branch_case("bgtz taken", make_i(mips_pkg::OP_BGTZ, 5'd3, 5'd0, off), pos, '0, 1'b1);
	branch_case("bgtz not taken", make_i(mips_pkg::OP_BGTZ, 5'd3, 5'd0, off), '0, '0, 1'b0);
	branch_case("blez taken", make_i(mips_pkg::OP_BLEZ, 5'd3, 5'd0, ~off), neg, '0, 1'b1);
	branch_case("blez not taken", make_i(mips_pkg::OP_BLEZ, 5'd3, 5'd0, off), pos, '0, 1'b0);
	branch_case("bgez taken",
		make_i(mips_pkg::OP_REGIMM, 5'd3, mips_pkg::RI_BGEZ, off), '0, '0, 1'b1);
	branch_case("bgez not taken",
		make_i(mips_pkg::OP_REGIMM, 5'd3, mips_pkg::RI_BGEZ, off), neg, '0, 1'b0);
	branch_case("bltz taken",
		make_i(mips_pkg::OP_REGIMM, 5'd3, mips_pkg::RI_BLTZ, ~off), neg, '0, 1'b1);
	branch_case("bltz not taken",
		make_i(mips_pkg::OP_REGIMM, 5'd3, mips_pkg::RI_BLTZ, off), '0, '0, 1'b0);
endtask

task automatic jumps_and_links();
	mips_pkg::word_t     pc;
	mips_pkg::word_t     pc_next;
	mips_pkg::word_t     jtgt;
	mips_pkg::word_t     a;
	mips_pkg::reg_addr_t rd;
	logic [25:0]         t26;
	// last word of a 256 MB region, so pc + 4 lands in the next one
	pc      = (32'($random(seed)) & 32'hF000_0000) | 32'h0FFF_FFFC;
	pc_next = pc + 32'd4;
	t26     = 26'($random(seed));
	a       = 32'($random(seed)) & 32'hFFFF_FFFC;
	rd      = 5'($random(seed));
	// upper four bits come from pc + 4
	jtgt = {pc_next[31:28], t26, 2'b00};
	flow_case("j", make_j(mips_pkg::OP_J, t26), pc, '0, '0, 1'b1, jtgt, '0, '0, 1'b0, 1'b1);
	flow_case("jr", make_r(5'd9, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR), pc, a, '0,
		1'b1, a, '0, '0, 1'b0, 1'b0);
	flow_case("jal", make_j(mips_pkg::OP_JAL, t26), pc, '0, '0,
		1'b1, jtgt, pc + 32'd8, mips_pkg::LINK_REG, 1'b1, 1'b1);
	flow_case("jalr", make_r(5'd9, 5'd0, rd, 5'd0, mips_pkg::FN_JALR), pc, a, '0,
		1'b1, a, pc + 32'd8, rd, 1'b1, 1'b0);
	// links even when not taken
	flow_case("bltzal", make_i(mips_pkg::OP_REGIMM, 5'd9, mips_pkg::RI_BLTZAL, 16'h0010),
		pc, 32'd5, '0, 1'b0, '0, pc + 32'd8, mips_pkg::LINK_REG, 1'b1, 1'b0);
endtask

`endif

/* test/tb_id_stage.sv */
module tb_id_stage;

	localparam int NUM_TESTS    = 6;
	localparam int RESET_CYCLES = 8;
	localparam int CLK_PERIOD   = 4;

	logic                clk;
	logic                arst_n_i;
	mips_pkg::word_t     pc_i;
	mips_pkg::inst_u     inst_i;
	logic                is_in_delayslot_i;
	logic                ex_wreg_i;
	mips_pkg::reg_addr_t ex_wd_i;
	mips_pkg::word_t     ex_wdata_i;
	logic                mem_wreg_i;
	mips_pkg::reg_addr_t mem_wd_i;
	mips_pkg::word_t     mem_wdata_i;
	mips_pkg::word_t     reg1_data_i;
	mips_pkg::word_t     reg2_data_i;
	logic                reg1_read_o;
	logic                reg2_read_o;
	mips_pkg::reg_addr_t reg1_addr_o;
	mips_pkg::reg_addr_t reg2_addr_o;
	logic                branch_flag_o;
	mips_pkg::word_t     branch_target_o;
	mips_pkg::word_t     link_addr_o;
	mips_pkg::alu_op_t   ex_aluop_o;
	mips_pkg::alu_sel_t  ex_alusel_o;
	mips_pkg::word_t     ex_reg1_o;
	mips_pkg::word_t     ex_reg2_o;
	mips_pkg::reg_addr_t ex_wd_o;
	logic                ex_wreg_o;
	mips_pkg::word_t     ex_link_addr_o;
	logic                ex_in_delayslot_o;

	integer seed;
	int     checks_done;

	id_stage id_stage_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// 50 cycles per test on top of reset
	initial begin
		#((RESET_CYCLES + 50 * NUM_TESTS) * CLK_PERIOD);
		abort_run("watchdog expired before the test sequence completed");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	`include "tb_id_tasks.svh"

	initial begin
		seed              = 42;
		checks_done       = 0;
		arst_n_i          = 1'b0;
		pc_i              = '0;
		inst_i            = IDLE_INST;
		is_in_delayslot_i = 1'b0;
		ex_wreg_i         = 1'b0;
		ex_wd_i           = '0;
		ex_wdata_i        = '0;
		mem_wreg_i        = 1'b0;
		mem_wd_i          = '0;
		mem_wdata_i       = '0;
		reg1_data_i       = '0;
		reg2_data_i       = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n_i = 1'b1;

		after_reset();
		imm_forms();
		reg_forms();
		forwarding();
		branches();
		jumps_and_links();

		if (checks_done == 0) begin
			abort_run("no checks were executed");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
